/* design/cache_dma_pkg.sv */
package cache_dma_pkg;

    //////////////////////////////////////////////////
    // Line geometry
    //////////////////////////////////////////////////

    // log2 of words per line, default and upper bound
    localparam int unsigned OFFSET_WIDTH_DEF = 2;
    localparam int unsigned OFFSET_WIDTH_MAX = 4;
    // Widest line the helpers accept
    localparam int unsigned LINE_MAX_W = 32 << OFFSET_WIDTH_MAX;

    // Access size, matches the memory port size field
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } size_e;

    //////////////////////////////////////////////////
    // Bus structs
    //////////////////////////////////////////////////

    // One memory request, 71 bits
    typedef struct packed {
        logic [31:0] addr;
        size_e       size;
        logic        wr;
        logic [31:0] wdata;
        logic [3:0]  wstrb;
    } mem_req_t;

    // Acknowledges steered back to one bypass unit
    typedef struct packed {
        logic addr_ok;
        logic data_ok;
    } fetch_rsp_t;

    // Line width in bits for a given offset width
    function automatic int unsigned MEM_LINE_W(input int unsigned offset_width);
        return 32 << offset_width;
    endfunction

    // Word select from a zero-extended line
    function automatic logic [31:0] word_of_line(input logic [LINE_MAX_W-1:0] line,
                                                 input logic [OFFSET_WIDTH_MAX-1:0] off);
        return line[{off, 5'b00000} +: 32];
    endfunction

    // Byte lanes touched by an access
    function automatic logic [3:0] strobe_of(input size_e size, input logic [1:0] addr_lo);
        case (size)
            SIZE_BYTE: strobe_of = 4'b0001 << addr_lo;
            SIZE_HALF: strobe_of = addr_lo[1] ? 4'b1100 : 4'b0011;
            default:   strobe_of = 4'b1111;
        endcase
    endfunction

endpackage

/* design/icache_dma.sv */
`timescale 1ns/100ps

module icache_dma #(
    parameter int unsigned OFFSET_WIDTH = cache_dma_pkg::OFFSET_WIDTH_DEF
) (
    input  logic                     clk,
    input  logic                     rstn,
    // Pipeline fetch side
    input  logic [31:0]              fetch_addr,
    input  logic                     fetch_valid,
    output logic                     fetch_ready,
    output logic [63:0]              fetch_inst,
    output logic                     fetch_pair,
    // Arbiter side
    output logic                     ireq,
    output cache_dma_pkg::mem_req_t  ireq_bus,
    input  cache_dma_pkg::fetch_rsp_t irsp,
    input  logic [cache_dma_pkg::MEM_LINE_W(OFFSET_WIDTH)-1:0] mem_rdata
);
    import cache_dma_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_REQ  = 2'd1,
        S_WAIT = 2'd2
    } state_t;

    state_t state;
    state_t next_state;

    // Word offset of the fetch inside its line
    logic [OFFSET_WIDTH-1:0] fetch_off;
    logic [OFFSET_WIDTH-1:0] next_off;

    //////////////////////////////////////////////////
    // Bypass FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: if (fetch_valid) next_state = S_REQ;
            S_REQ:  if (irsp.addr_ok) next_state = S_WAIT;
            S_WAIT: if (irsp.data_ok) next_state = S_IDLE;
            default: next_state = S_IDLE;
        endcase
    end

    // Request goes out in the same cycle valid is seen
    assign ireq = (state == S_IDLE && fetch_valid) || (state == S_REQ);
    // Ready when idle and quiet, or on the data beat
    assign fetch_ready = (state == S_IDLE && !fetch_valid) ||
                         (state == S_WAIT && irsp.data_ok);

    // Whole line read, address aligned down to line start
    always_comb begin
        ireq_bus.addr  = {fetch_addr[31:OFFSET_WIDTH+2], {(OFFSET_WIDTH+2){1'b0}}};
        ireq_bus.size  = SIZE_WORD;
        ireq_bus.wr    = 1'b0;
        ireq_bus.wdata = 32'd0;
        ireq_bus.wstrb = 4'b0000;
    end

    //////////////////////////////////////////////////
    // Dual instruction select
    //////////////////////////////////////////////////

    assign fetch_off = fetch_addr[OFFSET_WIDTH+1:2];
    assign next_off  = fetch_off + 1'b1;
    // No second slot at the last word of the line
    assign fetch_pair = ~&fetch_off;

    always_comb begin
        fetch_inst[31:0] = word_of_line(LINE_MAX_W'(mem_rdata), OFFSET_WIDTH_MAX'(fetch_off));
        if (fetch_pair) begin
            fetch_inst[63:32] = word_of_line(LINE_MAX_W'(mem_rdata),
                                             OFFSET_WIDTH_MAX'(next_off));
        end else begin
            fetch_inst[63:32] = 32'd0;
        end
    end

endmodule

/* design/dcache_dma.sv */
`timescale 1ns/100ps

module dcache_dma #(
    parameter int unsigned OFFSET_WIDTH = cache_dma_pkg::OFFSET_WIDTH_DEF
) (
    input  logic                      clk,
    input  logic                      rstn,
    // Pipeline data side
    input  logic                      data_valid,
    input  logic                      data_wr,
    input  logic                      data_signed,
    input  cache_dma_pkg::size_e      data_size,
    input  logic [31:0]               data_addr,
    input  logic [31:0]               data_wdata,
    output logic                      data_ready,
    output logic [31:0]               data_rdata,
    // Arbiter side
    output logic                      dreq,
    output cache_dma_pkg::mem_req_t   dreq_bus,
    input  cache_dma_pkg::fetch_rsp_t drsp,
    input  logic [cache_dma_pkg::MEM_LINE_W(OFFSET_WIDTH)-1:0] mem_rdata
);
    import cache_dma_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE = 2'd0,
        S_REQ  = 2'd1,
        S_WAIT = 2'd2
    } state_t;

    state_t state;
    state_t next_state;

    logic [31:0] load_word;
    // Addressed byte or half moved to bit 0
    logic [31:0] load_lane;

    //////////////////////////////////////////////////
    // Bypass FSM
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= S_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            S_IDLE: if (data_valid) next_state = S_REQ;
            S_REQ:  if (drsp.addr_ok) next_state = S_WAIT;
            S_WAIT: if (drsp.data_ok) next_state = S_IDLE;
            default: next_state = S_IDLE;
        endcase
    end

    assign dreq = (state == S_IDLE && data_valid) || (state == S_REQ);
    // Store completion is also the data_ok beat
    assign data_ready = (state == S_IDLE && !data_valid) ||
                        (state == S_WAIT && drsp.data_ok);

    //////////////////////////////////////////////////
    // Request build
    //////////////////////////////////////////////////

    always_comb begin
        dreq_bus.size = data_size;
        dreq_bus.wr   = data_wr;
        if (data_wr) begin
            // Write-through, word address plus byte strobes
            dreq_bus.addr  = {data_addr[31:2], 2'b00};
            dreq_bus.wstrb = strobe_of(data_size, data_addr[1:0]);
        end else begin
            // Loads fetch the whole line, nothing allocated
            dreq_bus.addr  = {data_addr[31:OFFSET_WIDTH+2], {(OFFSET_WIDTH+2){1'b0}}};
            dreq_bus.wstrb = 4'b0000;
        end
        // Same data on every lane, strobes pick the live ones
        case (data_size)
            SIZE_BYTE: dreq_bus.wdata = {4{data_wdata[7:0]}};
            SIZE_HALF: dreq_bus.wdata = {2{data_wdata[15:0]}};
            default:   dreq_bus.wdata = data_wdata;
        endcase
    end

    //////////////////////////////////////////////////
    // Load return
    //////////////////////////////////////////////////

    assign load_word = word_of_line(LINE_MAX_W'(mem_rdata),
                                    OFFSET_WIDTH_MAX'(data_addr[OFFSET_WIDTH+1:2]));
    assign load_lane = load_word >> {data_addr[1:0], 3'b000};

    // Sign or zero extension by size
    always_comb begin
        case (data_size)
            SIZE_BYTE: data_rdata = {{24{data_signed & load_lane[7]}}, load_lane[7:0]};
            SIZE_HALF: data_rdata = {{16{data_signed & load_lane[15]}}, load_lane[15:0]};
            default:   data_rdata = load_word;
        endcase
    end

endmodule

/* design/mem_arbiter.sv */
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                      clk,
    input  logic                      rstn,
    // Bypass unit side
    input  logic                      ireq,
    input  logic                      dreq,
    input  cache_dma_pkg::mem_req_t   ireq_bus,
    input  cache_dma_pkg::mem_req_t   dreq_bus,
    output cache_dma_pkg::fetch_rsp_t irsp,
    output cache_dma_pkg::fetch_rsp_t drsp,
    // Memory port
    output logic                      mem_req,
    output cache_dma_pkg::mem_req_t   mem_bus,
    input  logic                      mem_addr_ok,
    input  logic                      mem_data_ok
);
    // Owner encoding
    localparam logic OWN_I = 1'b0;
    localparam logic OWN_D = 1'b1;

    // Transaction accepted, waiting for data_ok
    logic busy;
    // Request on the port, not yet accepted
    logic offer;
    logic owner;
    logic last_winner;
    // Requester chosen this cycle
    logic grant;
    logic grant_req;
    logic accept;

    //////////////////////////////////////////////////
    // Selection
    //////////////////////////////////////////////////

    always_comb begin
        if (offer) begin
            // Stay on the offered request until accepted
            grant = owner;
        end else if (ireq && dreq) begin
            // Whoever lost last time goes first
            grant = (last_winner == OWN_I) ? OWN_D : OWN_I;
        end else if (dreq) begin
            grant = OWN_D;
        end else begin
            grant = OWN_I;
        end
    end

    assign grant_req = (grant == OWN_D) ? dreq : ireq;

    // No added cycle, port follows the granted unit directly
    assign mem_req = !busy && grant_req;
    assign mem_bus = (grant == OWN_D) ? dreq_bus : ireq_bus;
    assign accept  = mem_req && mem_addr_ok;

    //////////////////////////////////////////////////
    // Acknowledge steering
    //////////////////////////////////////////////////

    // addr_ok to the live grant, data_ok to the stored owner
    assign irsp.addr_ok = accept && (grant == OWN_I);
    assign drsp.addr_ok = accept && (grant == OWN_D);
    assign irsp.data_ok = busy && mem_data_ok && (owner == OWN_I);
    assign drsp.data_ok = busy && mem_data_ok && (owner == OWN_D);

    //////////////////////////////////////////////////
    // Grant state
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            busy        <= 1'b0;
            offer       <= 1'b0;
            owner       <= OWN_I;
            last_winner <= OWN_D;
        end else begin
            if (accept) begin
                busy        <= 1'b1;
                offer       <= 1'b0;
                owner       <= grant;
                last_winner <= grant;
            end else if (mem_req && !offer) begin
                // Lock the choice while memory stalls addr_ok
                offer <= 1'b1;
                owner <= grant;
            end
            if (busy && mem_data_ok) begin
                busy <= 1'b0;
            end
        end
    end

endmodule

/* design/cache_dma_top.sv */
`timescale 1ns/100ps

module cache_dma_top #(
    parameter int unsigned OFFSET_WIDTH = cache_dma_pkg::OFFSET_WIDTH_DEF
) (
    input  logic                    clk,
    input  logic                    rstn,
    // Fetch side
    input  logic [31:0]             fetch_addr,
    input  logic                    fetch_valid,
    output logic                    fetch_ready,
    output logic [63:0]             fetch_inst,
    output logic                    fetch_pair,
    // Load and store side
    input  logic                    data_valid,
    input  logic                    data_wr,
    input  cache_dma_pkg::size_e    data_size,
    input  logic [31:0]             data_addr,
    input  logic [31:0]             data_wdata,
    input  logic                    data_signed,
    output logic                    data_ready,
    output logic [31:0]             data_rdata,
    // External memory
    output logic                    mem_req,
    output cache_dma_pkg::mem_req_t mem_bus,
    input  logic                    mem_addr_ok,
    input  logic                    mem_data_ok,
    input  logic [cache_dma_pkg::MEM_LINE_W(OFFSET_WIDTH)-1:0] mem_rdata
);
    import cache_dma_pkg::*;

    // Bypass unit to arbiter
    logic       ireq;
    logic       dreq;
    mem_req_t   ireq_bus;
    mem_req_t   dreq_bus;
    fetch_rsp_t irsp;
    fetch_rsp_t drsp;

    //////////////////////////////////////////////////
    // Bypass units
    //////////////////////////////////////////////////

    icache_dma #(
        .OFFSET_WIDTH(OFFSET_WIDTH)
    ) u_icache_dma (
        .clk        (clk),
        .rstn       (rstn),
        .fetch_addr (fetch_addr),
        .fetch_valid(fetch_valid),
        .fetch_ready(fetch_ready),
        .fetch_inst (fetch_inst),
        .fetch_pair (fetch_pair),
        .ireq       (ireq),
        .ireq_bus   (ireq_bus),
        .irsp       (irsp),
        .mem_rdata  (mem_rdata)
    );

    dcache_dma #(
        .OFFSET_WIDTH(OFFSET_WIDTH)
    ) u_dcache_dma (
        .clk        (clk),
        .rstn       (rstn),
        .data_valid (data_valid),
        .data_wr    (data_wr),
        .data_signed(data_signed),
        .data_size  (data_size),
        .data_addr  (data_addr),
        .data_wdata (data_wdata),
        .data_ready (data_ready),
        .data_rdata (data_rdata),
        .dreq       (dreq),
        .dreq_bus   (dreq_bus),
        .drsp       (drsp),
        .mem_rdata  (mem_rdata)
    );

    // Single port, one transaction in flight
    mem_arbiter u_mem_arbiter (
        .clk        (clk),
        .rstn       (rstn),
        .ireq       (ireq),
        .dreq       (dreq),
        .ireq_bus   (ireq_bus),
        .dreq_bus   (dreq_bus),
        .irsp       (irsp),
        .drsp       (drsp),
        .mem_req    (mem_req),
        .mem_bus    (mem_bus),
        .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok)
    );

endmodule

/* sim/cache_dma_chk.sv */
`timescale 1ns/100ps

module cache_dma_chk (
    input logic                    clk,
    input logic                    rstn,
    input logic                    mem_req,
    input cache_dma_pkg::mem_req_t mem_bus,
    input logic                    mem_addr_ok,
    input logic                    mem_data_ok,
    input logic                    busy
);
    import cache_dma_pkg::*;

    //////////////////////////////////////////////////
    // Memory port protocol
    //////////////////////////////////////////////////

    // Offered request held steady until accepted
    req_hold: assert property (@(posedge clk) disable iff (!rstn)
        (mem_req && !mem_addr_ok) |=> (mem_req && $stable(mem_bus)))
        else $error("mem_req dropped or mem_bus changed before mem_addr_ok");

    // Only one transaction in flight
    no_accept_busy: assert property (@(posedge clk) disable iff (!rstn)
        mem_addr_ok |-> !busy)
        else $error("mem_addr_ok seen while a transaction is outstanding");

    // Data beat only for an accepted request
    data_in_busy: assert property (@(posedge clk) disable iff (!rstn)
        mem_data_ok |-> busy)
        else $error("mem_data_ok seen with no transaction outstanding");

endmodule

/* sim/cache_dma_mon.sv */
`timescale 1ns/100ps

module cache_dma_mon (
    input  logic                    clk,
    input  logic                    rstn,
    // DUT ports under watch
    input  logic                    fetch_valid,
    input  logic                    fetch_ready,
    input  logic [63:0]             fetch_inst,
    input  logic                    fetch_pair,
    input  logic                    data_valid,
    input  logic                    data_wr,
    input  cache_dma_pkg::size_e    data_size,
    input  logic                    data_ready,
    input  logic [31:0]             data_rdata,
    input  logic                    mem_req,
    input  cache_dma_pkg::mem_req_t mem_bus,
    input  logic                    mem_addr_ok,
    // Expected results of the tests in flight
    input  logic [63:0]             exp_inst,
    input  logic                    exp_pair,
    input  logic [31:0]             exp_data,
    input  int                      fetch_test,
    input  int                      data_test,
    output int                      pass_count,
    output int                      fail_count
);
    import cache_dma_pkg::*;

    logic  rstn_q;
    // Size field of the last accepted memory request
    size_e acc_size;

    always @(posedge clk) begin
        int npass;
        int nfail;
        logic ok;
        npass = 0;
        nfail = 0;
        rstn_q <= rstn;
        if (!rstn) begin
            pass_count <= 0;
            fail_count <= 0;
            acc_size   <= SIZE_WORD;
        end else begin
            // First cycle out of reset with the pipeline quiet
            if (!rstn_q && mem_req) begin
                $display("Memory request was active in the first cycle after reset");
                nfail = nfail + 1;
            end
            // One transaction in flight, the next data beat belongs to it
            if (mem_req && mem_addr_ok) begin
                acc_size <= mem_bus.size;
            end
            // Fetch completes on ready while valid
            if (fetch_valid && fetch_ready) begin
                ok = 1'b1;
                if (fetch_inst !== exp_inst) begin
                    $display("[FAIL] test %0d fetch_inst got %h expected %h",
                             fetch_test, fetch_inst, exp_inst);
                    ok = 1'b0;
                end
                if (fetch_pair !== exp_pair) begin
                    $display("[FAIL] test %0d fetch_pair got %h expected %h",
                             fetch_test, fetch_pair, exp_pair);
                    ok = 1'b0;
                end
                // Line reads for instructions go out as word size
                if (acc_size !== SIZE_WORD) begin
                    $display("[FAIL] test %0d mem_bus.size got %h expected %h",
                             fetch_test, acc_size, SIZE_WORD);
                    ok = 1'b0;
                end
                if (ok) begin
                    $display("[PASS] test %0d fetch %h pair %0d",
                             fetch_test, fetch_inst, fetch_pair);
                    npass = npass + 1;
                end else begin
                    nfail = nfail + 1;
                end
            end
            // Data side completes on ready while valid
            if (data_valid && data_ready) begin
                ok = 1'b1;
                // Request carries the pipeline access size
                if (acc_size !== data_size) begin
                    $display("[FAIL] test %0d mem_bus.size got %h expected %h",
                             data_test, acc_size, data_size);
                    ok = 1'b0;
                end
                if (!data_wr && data_rdata !== exp_data) begin
                    $display("[FAIL] test %0d data_rdata got %h expected %h",
                             data_test, data_rdata, exp_data);
                    ok = 1'b0;
                end
                if (!ok) begin
                    nfail = nfail + 1;
                end else if (data_wr) begin
                    $display("[PASS] test %0d store acknowledged", data_test);
                    npass = npass + 1;
                end else begin
                    $display("[PASS] test %0d load %h", data_test, data_rdata);
                    npass = npass + 1;
                end
            end
            pass_count <= pass_count + npass;
            fail_count <= fail_count + nfail;
        end
    end

endmodule

/* sim/cache_dma_tb.sv */
`timescale 1ns/100ps

module cache_dma_tb;
    import cache_dma_pkg::*;

    localparam int unsigned OFFSET_WIDTH = OFFSET_WIDTH_DEF;
    localparam int          LINE_W       = 32 << OFFSET_WIDTH;
    localparam int          MEM_BYTES    = 1024;
    localparam int          MAX_TESTS    = 64;
    localparam int          RESET_CYCLES = 16;

    logic clk;
    logic rstn;
    logic [31:0] fetch_addr;
    logic fetch_valid;
    logic fetch_ready;
    logic [63:0] fetch_inst;
    logic fetch_pair;
    logic data_valid;
    logic data_wr;
    size_e data_size;
    logic [31:0] data_addr;
    logic [31:0] data_wdata;
    logic data_signed;
    logic data_ready;
    logic [31:0] data_rdata;
    logic mem_req;
    mem_req_t mem_bus;
    logic mem_addr_ok;
    logic mem_data_ok;
    logic [LINE_W-1:0] mem_rdata;

    // Pattern table
    int kind_t [MAX_TESTS];
    logic [31:0] addr_t [MAX_TESTS];
    int size_t [MAX_TESTS];
    int sgn_t [MAX_TESTS];
    logic [31:0] wdata_t [MAX_TESTS];
    logic [63:0] exp_t [MAX_TESTS];
    int pair_t [MAX_TESTS];
    int group_t [MAX_TESTS];
    int n_tests;

    // Expected values handed to the monitor
    logic [63:0] exp_inst;
    logic exp_pair;
    logic [31:0] exp_data;
    int fetch_test;
    int data_test;
    int pass_count;
    int fail_count;

    int cycles;
    int cycle_limit;
    int seed;

    // Memory model state
    logic [7:0] mem [MEM_BYTES];
    logic in_flight;
    int unsigned wait_cnt;
    mem_req_t held;

    cache_dma_top #(
        .OFFSET_WIDTH(OFFSET_WIDTH)
    ) u_cache_dma_top (.*);

    cache_dma_mon u_cache_dma_mon (.*);

    bind mem_arbiter cache_dma_chk u_cache_dma_chk (.*);

    always #10 clk = ~clk;

    //////////////////////////////////////////////////
    // Memory model
    //////////////////////////////////////////////////

    always @(posedge clk) begin
        logic [9:0] base;
        mem_addr_ok <= 1'b0;
        mem_data_ok <= 1'b0;
        if (!rstn) begin
            in_flight <= 1'b0;
            wait_cnt  <= $unsigned($random(seed)) % 4;
        end else if (in_flight) begin
            if (wait_cnt == 0) begin
                base = held.addr[9:0];
                if (held.wr) begin
                    for (int k = 0; k < 4; k++)
                        if (held.wstrb[k])
                            mem[int'(base) + k] = held.wdata[k*8 +: 8];
                end else begin
                    for (int k = 0; k < LINE_W / 8; k++)
                        mem_rdata[k*8 +: 8] <= mem[int'(base) + k];
                end
                mem_data_ok <= 1'b1;
                in_flight   <= 1'b0;
                // Next accept delay, 0 to 3 cycles
                wait_cnt    <= $unsigned($random(seed)) % 4;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end else if (mem_req && !mem_addr_ok) begin
            if (wait_cnt == 0) begin
                mem_addr_ok <= 1'b1;
                held        <= mem_bus;
                in_flight   <= 1'b1;
                // Data beat 1 to 4 cycles after accept
                wait_cnt    <= $unsigned($random(seed)) % 4;
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    function automatic int load_patterns();
        int fd;
        int cnt;
        int n;
        string line;
        int k;
        int s;
        int sg;
        int pr;
        int gr;
        logic [31:0] a;
        logic [31:0] wd;
        logic [63:0] ex;
        n = 0;
        fd = $fopen("sim/cache_dma_patterns.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n < MAX_TESTS) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != "#") begin
                    cnt = $sscanf(line, "%d %h %d %d %h %h %d %d",
                                  k, a, s, sg, wd, ex, pr, gr);
                    if (cnt == 8) begin
                        kind_t[n]  = k;
                        addr_t[n]  = a;
                        size_t[n]  = s;
                        sgn_t[n]   = sg;
                        wdata_t[n] = wd;
                        exp_t[n]   = ex;
                        pair_t[n]  = pr;
                        group_t[n] = gr;
                        n = n + 1;
                    end
                end
            end
            $fclose(fd);
        end
        return n;
    endfunction

    // Kind 0 fetch, 1 load, 2 store
    task automatic issue_test(input int idx);
        @(posedge clk);
        if (kind_t[idx] == 0) begin
            fetch_addr  <= addr_t[idx];
            fetch_valid <= 1'b1;
            exp_inst    <= exp_t[idx];
            exp_pair    <= pair_t[idx][0];
            fetch_test  <= idx;
            do @(posedge clk); while (!(fetch_valid && fetch_ready));
            fetch_valid <= 1'b0;
        end else begin
            data_addr   <= addr_t[idx];
            data_wr     <= (kind_t[idx] == 2);
            data_size   <= size_e'(size_t[idx][1:0]);
            data_signed <= sgn_t[idx][0];
            data_wdata  <= wdata_t[idx];
            data_valid  <= 1'b1;
            exp_data    <= exp_t[idx][31:0];
            data_test   <= idx;
            do @(posedge clk); while (!(data_valid && data_ready));
            data_valid <= 1'b0;
        end
    endtask

    initial begin
        int i;
        clk = 1'b0;
        rstn = 1'b0;
        fetch_addr = 32'd0;
        fetch_valid = 1'b0;
        data_valid = 1'b0;
        data_wr = 1'b0;
        data_size = SIZE_WORD;
        data_addr = 32'd0;
        data_wdata = 32'd0;
        data_signed = 1'b0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata = '0;
        exp_inst = 64'd0;
        exp_pair = 1'b0;
        exp_data = 32'd0;
        fetch_test = 0;
        data_test = 0;
        seed = 27602;
        cycles = 0;
        // Byte at a is low 8 bits of 3a+1
        for (int a = 0; a < MEM_BYTES; a++)
            mem[a] = 8'((a * 3 + 1) & 255);
        n_tests = load_patterns();
        cycle_limit = n_tests * 12 + RESET_CYCLES;
        if (n_tests == 0) begin
            $display("No tests could be read from the pattern file");
            $display("Verification failed");
            $finish;
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            rstn <= 1'b1;
            i = 0;
            while (i < n_tests) begin
                // Group 1 runs this line and the next one together
                if (group_t[i] == 1 && i + 1 < n_tests) begin
                    fork
                        issue_test(i);
                        issue_test(i + 1);
                    join
                    i = i + 2;
                end else begin
                    issue_test(i);
                    i = i + 1;
                end
            end
            repeat (2) @(posedge clk);
            $display("Tests run %0d, passed %0d, failed %0d",
                     n_tests, pass_count, fail_count);
            if (fail_count == 0 && pass_count == n_tests) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

    // Run limit from test count
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, tests did not complete", cycles);
            $display("Verification failed");
            $finish;
        end
    end

endmodule

/* sim/cache_dma_patterns.txt */
# kind(0 fetch 1 load 2 store) addr size(0 b 1 h 2 w) signed wdata expected pair group
# group 1 runs the line together with the next one
0 00000000 2 0 00000000 1613100D0A070401 1 0
0 0000000C 2 0 00000000 000000002E2B2825 0 0
0 00000104 2 0 00000000 221F1C191613100D 1 0
1 00000020 2 0 00000000 000000006A676461 0 0
1 0000002B 0 1 00000000 00000000FFFFFF82 0 0
1 0000002B 0 0 00000000 0000000000000082 0 0
1 0000002A 1 1 00000000 00000000FFFF827F 0 0
1 0000002A 1 0 00000000 000000000000827F 0 0
2 00000041 0 0 000000A5 0000000000000000 0 0
1 00000041 0 1 00000000 00000000FFFFFFA5 0 0
1 00000041 0 0 00000000 00000000000000A5 0 0
1 00000040 2 0 00000000 00000000CAC7A5C1 0 0
2 00000052 1 0 00008001 0000000000000000 0 0
1 00000052 1 1 00000000 00000000FFFF8001 0 0
1 00000052 1 0 00000000 0000000000008001 0 0
2 00000060 2 0 DEADBEEF 0000000000000000 0 0
1 00000060 2 0 00000000 00000000DEADBEEF 0 0
1 00000063 0 1 00000000 00000000FFFFFFDE 0 0
0 00000080 2 0 00000000 9693908D8A878481 1 1
1 00000060 2 0 00000000 00000000DEADBEEF 0 0
0 0000001C 2 0 00000000 000000005E5B5855 0 1
1 00000052 1 0 00000000 0000000000008001 0 0
0 00000048 2 0 00000000 EEEBE8E5E2DFDCD9 1 1
2 00000042 0 0 0000003C 0000000000000000 0 0
1 00000042 0 0 00000000 000000000000003C 0 0

/* cache_dma.f */
design/cache_dma_pkg.sv
design/icache_dma.sv
design/dcache_dma.sv
design/mem_arbiter.sv
design/cache_dma_top.sv
sim/cache_dma_chk.sv
sim/cache_dma_mon.sv
sim/cache_dma_tb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= cache_dma_tb
FILELIST  ?= cache_dma.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
